/* hdl/cpuPkg.sv */
// widths, reset configuration, opcode and ALU enums, instruction/config/phase/control structs
package cpuPkg;

    localparam int dataWidth   = 8;  // register and data path
    localparam int addrWidth   = 8;  // program counter
    localparam int instrWidth  = 16; // one instruction word
    localparam int lenWidth    = 2;  // one phase length field, legal 1..3
    localparam int slotWidth   = 4;  // slot number, up to 10 slots per cycle
    localparam int opWidth     = 4;
    localparam int numRegs     = 4;
    localparam int regIdxWidth = 2;

    // opcode field of the instruction word, other values run as NOP
    typedef enum logic [opWidth-1:0] {
        NOP = 4'h0,
        LDI = 4'h1,
        MOV = 4'h2,
        ADD = 4'h3,
        SUB = 4'h4,
        AND = 4'h5,
        XOR = 4'h6,
        OUT = 4'h7,
        JMP = 4'h8
    } opcodeT;

    typedef enum logic [2:0] {
        ALU_PASS,   // b straight through, LDI and MOV
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_XOR
    } aluOpT;

    // instruction word, msb first
    typedef struct packed {
        logic [opWidth-1:0]     opcode;
        logic [regIdxWidth-1:0] rd;
        logic [regIdxWidth-1:0] rs;
        logic [dataWidth-1:0]   imm;
    } instrT;

    typedef struct packed {
        logic [lenWidth-1:0] fetchLen;
        logic [lenWidth-1:0] decodeLen;
        logic [lenWidth-1:0] execLen;
        logic                run;      // 0 parks the sequencer in slot 0
    } phaseCfgT;

    typedef struct packed {
        logic fetch;
        logic decode;
        logic exec;
    } phaseT;

    // decoded control, latched at the end of decode
    typedef struct packed {
        logic                   regWrite;
        logic                   useImm;
        aluOpT                  aluOp;
        logic                   isOut;
        logic                   isJump;
        logic [regIdxWidth-1:0] rd;
        logic [regIdxWidth-1:0] rs;
        logic [dataWidth-1:0]   imm;
    } ctrlT;

    // F=3 D=3 E=2, stopped
    localparam phaseCfgT resetCfg = '{fetchLen: 2'd3, decodeLen: 2'd3, execLen: 2'd2, run: 1'b0};

endpackage : cpuPkg

/* hdl/phaseConfig.sv */
// phaseConfig: run-time phase length and run register with zero-length clamp
`timescale 1ns/100ps

module phaseConfig import cpuPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     cfgWrite,  // one-cycle write strobe
    input  phaseCfgT cfgData,
    output phaseCfgT cfg
);

    phaseCfgT cfgQ;
    phaseCfgT cfgClamped;

    // a length of 0 would give an empty phase
    function automatic logic [lenWidth-1:0] clampLen(input logic [lenWidth-1:0] len);
        logic [lenWidth-1:0] res;
        res = len;
        if (len == '0) begin
            res = lenWidth'(1); // shortest legal phase
        end
        return res;
    endfunction

    always_comb begin
        cfgClamped.fetchLen  = clampLen(cfgData.fetchLen);
        cfgClamped.decodeLen = clampLen(cfgData.decodeLen);
        cfgClamped.execLen   = clampLen(cfgData.execLen);
        cfgClamped.run       = cfgData.run;
    end

    // sequencer only looks at this in slot 0
    // so a write mid-cycle waits for the next dead slot
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cfgQ <= resetCfg;
        end else if (cfgWrite) begin
            cfgQ <= cfgClamped;
        end
    end

    assign cfg = cfgQ;

endmodule : phaseConfig

/* hdl/phaseSequencer.sv */
// phaseSequencer: slot counter, length snapshot, fetch/decode/exec set-reset flags, done pulses
`timescale 1ns/100ps

module phaseSequencer import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  phaseCfgT             cfg,
    output logic [slotWidth-1:0] slot,
    output phaseT                phase,
    output logic                 fetchDone,   // last fetch slot
    output logic                 decodeDone,  // last decode slot
    output logic                 execDone     // last exec slot
);

    logic [slotWidth-1:0] slotQ;
    logic [slotWidth-1:0] slotNext;
    logic [lenWidth-1:0]  fLenQ;  // lengths frozen for the running cycle
    logic [lenWidth-1:0]  dLenQ;
    logic [lenWidth-1:0]  eLenQ;
    logic [slotWidth-1:0] fEnd;
    logic [slotWidth-1:0] dEnd;
    logic [slotWidth-1:0] lastSlot;
    logic                 runStart;
    logic                 fetchQ;
    logic                 decodeQ;
    logic                 execQ;

    // phase end slots, slot 0 is always dead
    assign fEnd     = slotWidth'(fLenQ);
    assign dEnd     = fEnd + slotWidth'(dLenQ);
    assign lastSlot = dEnd + slotWidth'(eLenQ);

    assign runStart = (slotQ == '0) && cfg.run;   // leave dead slot

    always_comb begin
        if (slotQ == '0) begin
            slotNext = runStart ? slotWidth'(1) : '0;  // park while stopped
        end else if (slotQ == lastSlot) begin
            slotNext = '0; // wrap at snapshot sum
        end else begin
            slotNext = slotQ + slotWidth'(1);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            slotQ <= '0;
            fLenQ <= resetCfg.fetchLen;
            dLenQ <= resetCfg.decodeLen;
            eLenQ <= resetCfg.execLen;
        end else begin
            slotQ <= slotNext;
            if (slotQ == '0) begin
                // snapshot only here, cycle length fixed once started
                fLenQ <= cfg.fetchLen;
                dLenQ <= cfg.decodeLen;
                eLenQ <= cfg.execLen;
            end
        end
    end

    assign fetchDone  = fetchQ && (slotQ == fEnd);
    assign decodeDone = decodeQ && (slotQ == dEnd);
    assign execDone   = execQ && (slotQ == lastSlot);

    // set/reset flags, each set wins over its own clear
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fetchQ  <= 1'b0;
            decodeQ <= 1'b0;
            execQ   <= 1'b0;
        end else begin
            if (runStart) fetchQ <= 1'b1;
            else if (fetchDone) fetchQ <= 1'b0;
            if (fetchDone) decodeQ <= 1'b1;      // decode follows fetch directly
            else if (decodeDone) decodeQ <= 1'b0;
            if (decodeDone) execQ <= 1'b1;
            else if (execDone) execQ <= 1'b0;    // back to dead slot
        end
    end

    assign slot         = slotQ;
    assign phase.fetch  = fetchQ;
    assign phase.decode = decodeQ;
    assign phase.exec   = execQ;

endmodule : phaseSequencer

/* hdl/phaseLatch.sv */
// phaseLatch: cleared register of any payload type, loaded on a phase strobe
`timescale 1ns/100ps

module phaseLatch #(
    parameter type payloadT = logic [7:0]
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    load,   // done pulse of the phase
    input  payloadT d,
    output payloadT q
);

    payloadT qReg;

    // cleared so the first decode sees an all-zero word (NOP)
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            qReg <= payloadT'('0);
        end else if (load) begin
            qReg <= d;
        end
    end

    assign q = qReg;

endmodule : phaseLatch

/* hdl/instrDecoder.sv */
// instrDecoder: opcode to ALU op, register write, immediate select, output and jump flags
`timescale 1ns/100ps

module instrDecoder import cpuPkg::*; (
    input  instrT instr,
    output ctrlT  ctrl
);

    opcodeT op;

    assign op = opcodeT'(instr.opcode);

    always_comb begin
        // default is a NOP, operand fields passed through
        ctrl.regWrite = 1'b0;
        ctrl.useImm   = 1'b0;
        ctrl.aluOp    = ALU_PASS;
        ctrl.isOut    = 1'b0;
        ctrl.isJump   = 1'b0;
        ctrl.rd       = instr.rd;
        ctrl.rs       = instr.rs;
        ctrl.imm      = instr.imm;

        case (op)
            LDI: begin
                ctrl.regWrite = 1'b1;
                ctrl.useImm   = 1'b1;   // rd = imm
            end
            MOV: begin
                ctrl.regWrite = 1'b1;   // rd = rs
            end
            ADD: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALU_ADD;
            end
            SUB: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALU_SUB;
            end
            AND: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALU_AND;
            end
            XOR: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALU_XOR;
            end
            OUT: ctrl.isOut  = 1'b1;    // shows rs
            JMP: ctrl.isJump = 1'b1;    // pc = imm
            default: begin
                // NOP and unused codes, nothing changes but pc
            end
        endcase
    end

endmodule : instrDecoder

/* hdl/execUnit.sv */
// execUnit: four-entry register file, ALU, program counter and output pulse
`timescale 1ns/100ps

module execUnit import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 commit,    // execDone
    input  ctrlT                 ctrl,
    output logic [addrWidth-1:0] pc,
    output logic [dataWidth-1:0] outData,
    output logic                 outValid
);

    logic [dataWidth-1:0] regFile [numRegs];
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] aluRes;
    logic [addrWidth-1:0] pcQ;
    logic [dataWidth-1:0] outDataQ;
    logic                 outValidQ;

    assign opA = regFile[ctrl.rd];
    assign opB = ctrl.useImm ? ctrl.imm : regFile[ctrl.rs];

    // results wrap at 8 bits
    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD: aluRes = opA + opB;
            ALU_SUB: aluRes = opA - opB;
            ALU_AND: aluRes = opA & opB;
            ALU_XOR: aluRes = opA ^ opB;
            default: aluRes = opB;      // pass, LDI and MOV
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regFile[i] <= '0;
            end
        end else if (commit && ctrl.regWrite) begin
            regFile[ctrl.rd] <= aluRes;
        end
    end

    // pc moves once per instruction, at the end of exec
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcQ <= '0;
        end else if (commit) begin
            if (ctrl.isJump) begin
                pcQ <= addrWidth'(ctrl.imm);
            end else begin
                pcQ <= pcQ + addrWidth'(1);   // wraps at 256
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValidQ <= 1'b0;
        end else begin
            outValidQ <= commit && ctrl.isOut; // single cycle, lands in dead slot
        end
    end

    // output value holds until the next OUT
    always_ff @(posedge clk) begin
        if (commit && ctrl.isOut) begin
            outDataQ <= regFile[ctrl.rs];
        end
    end

    assign pc       = pcQ;
    assign outData  = outDataQ;
    assign outValid = outValidQ;

endmodule : execUnit

/* hdl/phaseCpu.sv */
// phaseCpu: top level joining config register, sequencer, instruction and control latches, decoder, execute unit
`timescale 1ns/100ps

module phaseCpu import cpuPkg::*; (
    input  logic                  clk,
    input  logic                  arstN,
    // configuration
    input  logic                  cfgWrite,
    input  phaseCfgT              cfgData,
    // instruction fetch, memory outside and combinational
    output logic [addrWidth-1:0]  instrAddr,
    input  logic [instrWidth-1:0] instrData,
    // output port
    output logic [dataWidth-1:0]  outData,
    output logic                  outValid,
    // observation
    output phaseT                 phase,
    output logic [slotWidth-1:0]  slot
);

    phaseCfgT cfg;
    logic     fetchDone;
    logic     decodeDone;
    logic     execDone;
    instrT    instrQ;   // held from end of fetch
    ctrlT     ctrlD;
    ctrlT     ctrlQ;    // held from end of decode

    phaseConfig config_i (
        .clk      (clk),
        .arstN    (arstN),
        .cfgWrite (cfgWrite),
        .cfgData  (cfgData),
        .cfg      (cfg)
    );

    phaseSequencer seq_i (
        .clk        (clk),
        .arstN      (arstN),
        .cfg        (cfg),
        .slot       (slot),
        .phase      (phase),
        .fetchDone  (fetchDone),
        .decodeDone (decodeDone),
        .execDone   (execDone)
    );

    phaseLatch #(.payloadT(instrT)) instrLatch_i (
        .clk   (clk),
        .arstN (arstN),
        .load  (fetchDone),
        .d     (instrT'(instrData)),
        .q     (instrQ)
    );

    instrDecoder decoder_i (
        .instr (instrQ),
        .ctrl  (ctrlD)
    );

    phaseLatch #(.payloadT(ctrlT)) ctrlLatch_i (
        .clk   (clk),
        .arstN (arstN),
        .load  (decodeDone),
        .d     (ctrlD),
        .q     (ctrlQ)
    );

    // pc doubles as the fetch address
    execUnit exec_i (
        .clk      (clk),
        .arstN    (arstN),
        .commit   (execDone),
        .ctrl     (ctrlQ),
        .pc       (instrAddr),
        .outData  (outData),
        .outValid (outValid)
    );

endmodule : phaseCpu

/* test/phaseCpu_props.sv */
// bound assertions on phase overlap, reset state and output pulse, plus a failure count
`timescale 1ns/100ps

module phaseCpu_props import cpuPkg::*; (
    input logic                 clk,
    input logic                 arstN,
    input phaseT                phase,
    input logic                 outValid,
    input logic [addrWidth-1:0] instrAddr,
    input logic [slotWidth-1:0] slot
);

    int failCount = 0;   // failed assertions so far

    phaseExclusive: assert property (@(posedge clk) $countones(phase) <= 1)
        else begin
            failCount++;
            $error("more than one phase level high");
        end

    // everything parked and cleared while reset is held
    resetState: assert property (@(posedge clk)
        !arstN |-> (phase == '0 && !outValid && instrAddr == '0 && slot == '0))
        else begin
            failCount++;
            $error("state not cleared during reset");
        end

    pulseShort: assert property (@(posedge clk) disable iff (!arstN) outValid |=> !outValid)
        else begin
            failCount++;
            $error("output pulse longer than one cycle");
        end

    pulseInDead: assert property (@(posedge clk) disable iff (!arstN)
        outValid |-> (slot == '0 && phase == '0))   // lands after execDone
        else begin
            failCount++;
            $error("output pulse outside the dead slot");
        end

endmodule : phaseCpu_props

bind phaseCpu phaseCpu_props props_i (
    .clk       (clk),
    .arstN     (arstN),
    .phase     (phase),
    .outValid  (outValid),
    .instrAddr (instrAddr),
    .slot      (slot)
);

/* test/phaseCpuChecker.sv */
// config model, phase width, slot, dead slot, parked address, output value and interval checks
`timescale 1ns/100ps

module phaseCpuChecker import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 cfgWrite,
    input  phaseCfgT             cfgData,
    input  logic [addrWidth-1:0] instrAddr,
    input  logic [dataWidth-1:0] outData,
    input  logic                 outValid,
    input  phaseT                phase,
    input  logic [slotWidth-1:0] slot,
    output int                   errCount,
    output int                   pulseCount
);

    logic [dataWidth-1:0] expQ[$];   // expected outputs in order
    phaseCfgT cfgModel;              // written config
    phaseCfgT snap;                  // lengths in force for this cycle
    int       fCnt;
    int       dCnt;
    int       eCnt;
    int       deadCnt;
    int       acc;                   // cycle lengths started since the last pulse
    int       sinceOut;
    int       slotExp;               // position inside the instruction cycle
    logic     haveCycle;
    logic     steadyCyc;
    logic     havePulse;
    logic     steadyOut;

    function automatic int lenOf(input logic [1:0] l);
        return (l == 2'd0) ? 1 : int'(l);  // zero written means one
    endfunction

    function automatic int cycLen(input phaseCfgT c);
        return 1 + int'(c.fetchLen) + int'(c.decodeLen) + int'(c.execLen);
    endfunction

    task automatic expectOut(input logic [dataWidth-1:0] v);
        expQ.push_back(v);
    endtask

    task automatic valueErr(input string name, input int got, input int want);
        $display("ERR %0t %s got %0h expected %0h", $time, name, got, want);
        errCount++;
    endtask

    task automatic plainErr(input string msg);
        $display("error at %0t: %s", $time, msg);
        errCount++;
    endtask

    initial begin
        errCount   = 0;
        pulseCount = 0;
    end

    always @(posedge clk) begin
        if (!arstN) begin
            cfgModel  = '{fetchLen: 2'd3, decodeLen: 2'd3, execLen: 2'd2, run: 1'b0};
            snap      = cfgModel;
            fCnt      = 0;
            dCnt      = 0;
            eCnt      = 0;
            deadCnt   = 0;
            acc       = 0;
            sinceOut  = 0;
            slotExp   = 0;
            haveCycle = 0;
            steadyCyc = 0;
            havePulse = 0;
            steadyOut = 0;
            pulseCount <= 0;
            expQ.delete();   // tb refills after reset
            if (phase != '0) valueErr("phase", phase, 0);
            if (outValid) valueErr("outValid", outValid, 0);
            if (instrAddr != '0) valueErr("instrAddr", instrAddr, 0);
        end else begin
            sinceOut++;
            if ($countones(phase) > 1) plainErr("phase levels overlap");
            if (!cfgModel.run && (phase != '0 || outValid))
                plainErr("activity while the run bit is off");
            // pc stays at 0 until the first instruction cycle
            if (!haveCycle && instrAddr != '0) valueErr("instrAddr", instrAddr, 0);
            if (phase == '0) slotExp = 0;   // dead slot
            else slotExp++;
            if (slot != slotExp) valueErr("slot", slot, slotExp);
            // widths checked when the level falls
            if (phase.fetch) begin
                if (fCnt == 0) begin   // new instruction cycle
                    if (haveCycle && steadyCyc && deadCnt != 1)
                        plainErr($sformatf("%0d dead cycles between instructions", deadCnt));
                    haveCycle = 1;
                    steadyCyc = 1;
                    deadCnt   = 0;
                    acc += cycLen(snap);
                end
                fCnt++;
            end else if (fCnt > 0) begin
                if (fCnt != snap.fetchLen) valueErr("fetch width", fCnt, snap.fetchLen);
                fCnt = 0;
            end
            if (phase.decode) dCnt++;
            else if (dCnt > 0) begin
                if (dCnt != snap.decodeLen) valueErr("decode width", dCnt, snap.decodeLen);
                dCnt = 0;
            end
            if (phase.exec) eCnt++;
            else if (eCnt > 0) begin
                if (eCnt != snap.execLen) valueErr("exec width", eCnt, snap.execLen);
                eCnt = 0;
            end
            if (phase == '0) deadCnt++;
            if (outValid) begin
                pulseCount <= pulseCount + 1;
                if (expQ.size() == 0) plainErr("output pulse with no expected value left");
                else if (outData != expQ[0]) valueErr("outData", outData, expQ[0]);
                if (expQ.size() != 0) void'(expQ.pop_front());
                if (havePulse && steadyOut && sinceOut != acc)
                    valueErr("out interval", sinceOut, acc);
                havePulse = 1;
                steadyOut = 1;
                sinceOut  = 0;
                acc       = 0;
            end
            if (!cfgModel.run) begin   // parked so timing restarts
                steadyCyc = 0;
                steadyOut = 0;
            end
            if (phase == '0) snap = cfgModel;   // sequencer freezes lengths in the dead slot
            if (cfgWrite) begin
                cfgModel.fetchLen  = 2'(lenOf(cfgData.fetchLen));
                cfgModel.decodeLen = 2'(lenOf(cfgData.decodeLen));
                cfgModel.execLen   = 2'(lenOf(cfgData.execLen));
                cfgModel.run       = cfgData.run;
            end
        end
    end

endmodule : phaseCpuChecker

/* test/phaseCpuTb.sv */
// clock, reset, pattern file, program ROM, run control, reconfig, timeout and closing report
`timescale 1ns/100ps

module phaseCpuTb import cpuPkg::*; ();

    localparam int numTests   = 3;
    localparam int recWords   = 24;
    localparam int parkCycles = 40;
    localparam int tailCycles = 40;

    logic                  clk;
    logic                  arstN;
    logic                  cfgWrite;
    phaseCfgT              cfgData;
    logic [addrWidth-1:0]  instrAddr;
    logic [instrWidth-1:0] instrData;
    logic [dataWidth-1:0]  outData;
    logic                  outValid;
    phaseT                 phase;
    logic [slotWidth-1:0]  slot;
    logic [15:0]           pat [0:numTests*recWords-1];
    logic [instrWidth-1:0] rom [0:15];
    int                    chkErrors;
    int                    pulseCount;
    int                    cycleCount;
    int                    limit;

    always #2 clk = ~clk;   // 4 ns period

    // combinational program memory of 16 words
    assign instrData = (instrAddr < 16) ? rom[instrAddr[3:0]] : '0;

    phaseCpu dut_i (
        .clk       (clk),
        .arstN     (arstN),
        .cfgWrite  (cfgWrite),
        .cfgData   (cfgData),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .outData   (outData),
        .outValid  (outValid),
        .phase     (phase),
        .slot      (slot)
    );

    phaseCpuChecker chk_i (
        .clk        (clk),
        .arstN      (arstN),
        .cfgWrite   (cfgWrite),
        .cfgData    (cfgData),
        .instrAddr  (instrAddr),
        .outData    (outData),
        .outValid   (outValid),
        .phase      (phase),
        .slot       (slot),
        .errCount   (chkErrors),
        .pulseCount (pulseCount)
    );

    // nibbles F D E x of a pattern word
    function automatic phaseCfgT wordToCfg(input logic [15:0] w, input logic run);
        phaseCfgT c;
        c.fetchLen  = w[13:12];
        c.decodeLen = w[9:8];
        c.execLen   = w[5:4];
        c.run       = run;
        return c;
    endfunction

    function automatic int cycleBound(input logic [15:0] w);
        int n;
        n = 1;
        for (int i = 1; i < 4; i++) begin
            n += (w[i*4 +: 2] == 2'd0) ? 1 : int'(w[i*4 +: 2]);
        end
        return n;
    endfunction

    task automatic writeCfg(input phaseCfgT c);
        @(posedge clk);
        cfgWrite <= 1'b1;
        cfgData  <= c;
        @(posedge clk);
        cfgWrite <= 1'b0;
    endtask

    task automatic waitPulses(input int n);
        while (pulseCount < n) @(posedge clk);
    endtask

    task automatic runTest(input int t);
        int base;
        base = t * recWords;
        @(posedge clk);
        arstN <= 1'b0;
        for (int i = 0; i < 16; i++) rom[i] <= pat[base+8+i];
        repeat (8) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < pat[base+3]; i++) chk_i.expectOut(pat[base+4+i][7:0]);
        // lengths written with run off so nothing may move
        writeCfg(wordToCfg(pat[base], 1'b0));
        repeat (parkCycles) @(posedge clk);
        writeCfg(wordToCfg(pat[base], 1'b1));
        if (pat[base+1] != 0) begin   // new lengths mid program
            waitPulses(pat[base+1]);
            writeCfg(wordToCfg(pat[base+2], pat[base+2][0]));
        end
        waitPulses(pat[base+3]);
        repeat (tailCycles) @(posedge clk);   // extra pulses show up in the checker
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > limit) begin
            $display("timeout: tests did not finish within %0d cycles", limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        int total;
        clk        = 1'b0;
        arstN      = 1'b1;
        cfgWrite   = 1'b0;
        cfgData    = '0;
        cycleCount = 0;
        for (int i = 0; i < 16; i++) rom[i] = '0;
        $readmemh("test/phaseCpu_patterns.txt", pat);
        limit = 50;
        for (int t = 0; t < numTests; t++) begin
            limit += 20 + parkCycles + tailCycles;
            limit += 16 * ((cycleBound(pat[t*recWords]) > cycleBound(pat[t*recWords+2]))
                ? cycleBound(pat[t*recWords]) : cycleBound(pat[t*recWords+2]));
        end
        for (int t = 0; t < numTests; t++) runTest(t);
        total = chkErrors + dut_i.props_i.failCount;
        $display("errors: checker %0d, assertions %0d", chkErrors, dut_i.props_i.failCount);
        if (total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : phaseCpuTb

/* phaseCpu.f */
hdl/cpuPkg.sv
hdl/phaseConfig.sv
hdl/phaseSequencer.sv
hdl/phaseLatch.sv
hdl/instrDecoder.sv
hdl/execUnit.sv
hdl/phaseCpu.sv
test/phaseCpu_props.sv
test/phaseCpuChecker.sv
test/phaseCpuTb.sv

/* test/phaseCpu_patterns.txt */
// record of 24 hex words per test
// cfg FDEx, reconfig after n outputs, new cfg FDEr, output count, 4 expected, 16 program words
// arithmetic, lengths 3 3 2
3320 0000 0000 0004
0017 0002 0007 00F8
1012 1405 3100 7000 4100 180F 5200 7000
6100 2C00 7300 4200 7000 800D 0000 0000
// jump over LDI/OUT, lengths 1 1 1
1110 0000 0000 0002
0011 0022 0000 0000
1011 7000 8005 10EE 7000 1422 7100 8007
0000 0000 0000 0000 0000 0000 0000 0000
// reconfig after first output to 3 0 1, decode clamps to 1
2130 0001 3011 0004
0040 0080 0000 0000
1040 7000 3000 7000 3000 7000 7000 8007
0000 0000 0000 0000 0000 0000 0000 0000
